// File: rvfi_pipe_pkg.sv
package rvfi_pipe_pkg;

    // rv32i major opcodes handled here
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        SYSTEM = 7'b1110011
    } opcode_e;

    // alu function select
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // the only legal SYSTEM encoding
    localparam logic [31:0] ECALL_INST = 32'h0000_0073;

    // decode to execute
    typedef struct packed {
        logic        valid;
        logic [31:0] inst;
        logic [31:0] pc;
        alu_op_e     alu_op;
        logic [31:0] op_a;
        logic [31:0] op_b;
        // unused sources carry address zero
        logic [4:0]  rs1_addr;
        logic [4:0]  rs2_addr;
        logic [31:0] rs1_rdata;
        logic [31:0] rs2_rdata;
        logic [4:0]  rd_addr;
        // low for x0 destinations, so a match always means rd != 0
        logic        load_regfile;
        logic        trap;
        logic        halt;
    } dec_op_t;

    // execute to commit
    typedef struct packed {
        dec_op_t     op;
        logic [31:0] result;
    } ex_res_t;

    // retired instruction record
    typedef struct packed {
        logic [63:0] order;
        logic [31:0] inst;
        logic [31:0] pc_rdata;
        logic [31:0] pc_wdata;
        logic [4:0]  rs1_addr;
        logic [4:0]  rs2_addr;
        logic [31:0] rs1_rdata;
        logic [31:0] rs2_rdata;
        logic [4:0]  rd_addr;
        logic [31:0] rd_wdata;
        logic        load_regfile;
        logic        trap;
        logic        halt;
    } commit_t;

endpackage

// File: rv_decode_stage.sv
module rv_decode_stage #(
    parameter int          IN_DEPTH = 4,
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic                    itf,
    input  logic                    rst,
    input  logic                    in_valid,
    input  logic [31:0]             in_inst,
    output logic                    in_credit,
    input  logic                    hold,
    output logic [4:0]              rf_raddr1,
    output logic [4:0]              rf_raddr2,
    input  logic [31:0]             rf_rdata1,
    input  logic [31:0]             rf_rdata2,
    input  rvfi_pipe_pkg::ex_res_t  fwd_ex,
    output rvfi_pipe_pkg::dec_op_t  dec
);
    import rvfi_pipe_pkg::*;

    localparam int PW = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int CW = $clog2(IN_DEPTH + 1);

    logic [31:0]   q_mem [IN_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          pop;
    logic [31:0]   pc;
    logic [31:0]   head;
    opcode_e       opc;
    logic [2:0]    f3;
    logic [6:0]    f7;
    logic          use_rs1;
    logic          use_rs2;
    logic [4:0]    rs1;
    logic [4:0]    rs2;
    logic [31:0]   rs1_val;
    logic [31:0]   rs2_val;
    logic [31:0]   imm_i;
    logic [31:0]   imm_u;
    alu_op_e       f3_alu;
    dec_op_t       dec_d;

    // one pop per cycle unless commit is stalled
    assign pop = (count != '0) && !hold;

    // input queue, payload has no reset
    always_ff @(posedge itf) begin
        if (in_valid) begin
            q_mem[wr_ptr] <= in_inst;
        end
    end

    always_ff @(posedge itf) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
            pc        <= RESET_PC;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PW'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                pc     <= pc + 32'd4;
            end
            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // credit goes back the cycle after the pop
            in_credit <= pop;
        end
    end

    // field split
    assign head  = q_mem[rd_ptr];
    assign opc   = opcode_e'(head[6:0]);
    assign f3    = head[14:12];
    assign f7    = head[31:25];
    assign imm_i = {{20{head[31]}}, head[31:20]};
    assign imm_u = {head[31:12], 12'h000};

    // only report sources the instruction really reads
    assign use_rs1   = (opc == OP) || (opc == OP_IMM);
    assign use_rs2   = (opc == OP);
    assign rs1       = use_rs1 ? head[19:15] : 5'd0;
    assign rs2       = use_rs2 ? head[24:20] : 5'd0;
    assign rf_raddr1 = rs1;
    assign rf_raddr2 = rs2;

    // execute result beats commit/regfile path
    assign rs1_val = (fwd_ex.op.valid && fwd_ex.op.load_regfile && fwd_ex.op.rd_addr == rs1) ?
                     fwd_ex.result : rf_rdata1;
    assign rs2_val = (fwd_ex.op.valid && fwd_ex.op.load_regfile && fwd_ex.op.rd_addr == rs2) ?
                     fwd_ex.result : rf_rdata2;

    // funct3 map, bit 30 picks sub/sra
    always_comb begin
        case (f3)
            3'd0:    f3_alu = (opc == OP && head[30]) ? ALU_SUB : ALU_ADD;
            3'd1:    f3_alu = ALU_SLL;
            3'd2:    f3_alu = ALU_SLT;
            3'd3:    f3_alu = ALU_SLTU;
            3'd4:    f3_alu = ALU_XOR;
            3'd5:    f3_alu = head[30] ? ALU_SRA : ALU_SRL;
            3'd6:    f3_alu = ALU_OR;
            default: f3_alu = ALU_AND;
        endcase
    end

    always_comb begin
        dec_d           = '0;
        dec_d.valid     = pop;
        dec_d.inst      = head;
        dec_d.pc        = pc;
        dec_d.alu_op    = ALU_PASS_B;
        dec_d.rs1_addr  = rs1;
        dec_d.rs2_addr  = rs2;
        dec_d.rs1_rdata = rs1_val;
        dec_d.rs2_rdata = rs2_val;
        dec_d.rd_addr   = head[11:7];
        case (opc)
            OP: begin
                dec_d.alu_op = f3_alu;
                dec_d.op_a   = rs1_val;
                dec_d.op_b   = rs2_val;
                // funct7 must be zero except for sub and sra
                dec_d.trap   = !((f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
            end
            OP_IMM: begin
                dec_d.alu_op = f3_alu;
                dec_d.op_a   = rs1_val;
                dec_d.op_b   = imm_i;
                if (f3 == 3'd1) begin
                    dec_d.trap = (f7 != 7'h00);
                end else if (f3 == 3'd5) begin
                    dec_d.trap = (f7 != 7'h00) && (f7 != 7'h20);
                end
            end
            LUI: begin
                dec_d.op_b = imm_u;
            end
            AUIPC: begin
                dec_d.alu_op = ALU_ADD;
                dec_d.op_a   = pc;
                dec_d.op_b   = imm_u;
            end
            SYSTEM: begin
                dec_d.halt = (head == ECALL_INST);
                dec_d.trap = (head != ECALL_INST);
            end
            default: dec_d.trap = 1'b1;
        endcase
        // x0 writes retire with nothing written
        dec_d.load_regfile = (opc inside {OP, OP_IMM, LUI, AUIPC}) && !dec_d.trap &&
                             (head[11:7] != 5'd0);
    end

    always_ff @(posedge itf) begin
        if (rst) begin
            dec.valid <= 1'b0;
        end else if (!hold) begin
            dec <= dec_d;
        end
    end

    // source must respect its credits
    assert property (@(posedge itf) disable iff (rst) in_valid |-> (count != CW'(IN_DEPTH)));

endmodule

// File: rv_execute_stage.sv
module rv_execute_stage (
    input  logic                    itf,
    input  logic                    rst,
    input  logic                    hold,
    input  rvfi_pipe_pkg::dec_op_t  dec,
    output rvfi_pipe_pkg::ex_res_t  res
);
    import rvfi_pipe_pkg::*;

    logic        byp1;
    logic        byp2;
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  shamt;
    logic [31:0] alu_y;
    dec_op_t     op_n;

    // previous instruction sits in res while this one was being decoded,
    // so decode could not see it yet
    assign byp1 = res.op.valid && res.op.load_regfile && (res.op.rd_addr == dec.rs1_addr);
    assign byp2 = res.op.valid && res.op.load_regfile && (res.op.rd_addr == dec.rs2_addr);

    // a hit implies the operand came from that register
    assign a     = byp1 ? res.result : dec.op_a;
    assign b     = byp2 ? res.result : dec.op_b;
    assign shamt = b[4:0];

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:    alu_y = a + b;
            ALU_SUB:    alu_y = a - b;
            ALU_SLL:    alu_y = a << shamt;
            ALU_SLT:    alu_y = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU:   alu_y = {31'd0, a < b};
            ALU_XOR:    alu_y = a ^ b;
            ALU_SRL:    alu_y = a >> shamt;
            ALU_SRA:    alu_y = $unsigned($signed(a) >>> shamt);
            ALU_OR:     alu_y = a | b;
            ALU_AND:    alu_y = a & b;
            ALU_PASS_B: alu_y = b;
            default:    alu_y = 32'd0;
        endcase
    end

    // refresh the record with bypassed values
    always_comb begin
        op_n           = dec;
        op_n.op_a      = a;
        op_n.op_b      = b;
        op_n.rs1_rdata = byp1 ? res.result : dec.rs1_rdata;
        op_n.rs2_rdata = byp2 ? res.result : dec.rs2_rdata;
    end

    // res also feeds decode forwarding
    always_ff @(posedge itf) begin
        if (rst) begin
            res.op.valid <= 1'b0;
        end else if (!hold) begin
            res.op     <= op_n;
            res.result <= alu_y;
        end
    end

endmodule

// File: rv_commit_stage.sv
module rv_commit_stage #(
    parameter int OUT_CREDITS = 2
) (
    input  logic                    itf,
    input  logic                    rst,
    input  rvfi_pipe_pkg::ex_res_t  res,
    input  logic [4:0]              rf_raddr1,
    input  logic [4:0]              rf_raddr2,
    output logic [31:0]             rf_rdata1,
    output logic [31:0]             rf_rdata2,
    output logic                    hold,
    output logic                    out_valid,
    output rvfi_pipe_pkg::commit_t  out_rec,
    input  logic                    out_credit
);
    import rvfi_pipe_pkg::*;

    localparam int CW = $clog2(OUT_CREDITS + 1);

    ex_res_t       cm_q;
    logic [63:0]   order_q;
    logic [CW-1:0] credits;
    logic [31:0]   regs [1:31];
    logic          retire_wr;

    // pending result first, then the array, x0 reads zero
    function automatic logic [31:0] read_port(input logic [4:0] addr);
        logic [31:0] val;
        if (addr == 5'd0) begin
            val = 32'd0;
        end else if (cm_q.op.valid && cm_q.op.load_regfile && cm_q.op.rd_addr == addr) begin
            val = cm_q.result;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        rf_rdata1 = read_port(rf_raddr1);
        rf_rdata2 = read_port(rf_raddr2);
    end

    // present a record only while a credit is held
    assign out_valid = cm_q.op.valid && (credits != '0);
    // finished record with nowhere to go stalls everything
    assign hold      = cm_q.op.valid && (credits == '0);
    assign retire_wr = out_valid && cm_q.op.load_regfile;

    always_ff @(posedge itf) begin
        if (rst) begin
            cm_q.op.valid <= 1'b0;
        end else if (!hold) begin
            cm_q <= res;
        end
    end

    // write back at retirement
    always_ff @(posedge itf) begin
        if (retire_wr) begin
            regs[cm_q.op.rd_addr] <= cm_q.result;
        end
    end

    always_ff @(posedge itf) begin
        if (rst) begin
            order_q <= 64'd0;
            credits <= CW'(OUT_CREDITS);
        end else begin
            if (out_valid) begin
                order_q <= order_q + 64'd1;
            end
            // spend on send, refill on returned pulse
            case ({out_valid, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // record view of the retiring instruction
    always_comb begin
        out_rec              = '0;
        out_rec.order        = order_q;
        out_rec.inst         = cm_q.op.inst;
        out_rec.pc_rdata     = cm_q.op.pc;
        out_rec.pc_wdata     = cm_q.op.pc + 32'd4;
        out_rec.rs1_addr     = cm_q.op.rs1_addr;
        out_rec.rs2_addr     = cm_q.op.rs2_addr;
        out_rec.rs1_rdata    = cm_q.op.rs1_rdata;
        out_rec.rs2_rdata    = cm_q.op.rs2_rdata;
        out_rec.load_regfile = cm_q.op.load_regfile;
        out_rec.trap         = cm_q.op.trap;
        out_rec.halt         = cm_q.op.halt;
        // no destination reported when nothing is written
        if (cm_q.op.load_regfile) begin
            out_rec.rd_addr  = cm_q.op.rd_addr;
            out_rec.rd_wdata = cm_q.result;
        end
    end

    // consumer returns no more than it was given
    assert property (@(posedge itf) disable iff (rst) credits <= CW'(OUT_CREDITS));
    // x0 is never a write target
    assert property (@(posedge itf) disable iff (rst) retire_wr |-> (cm_q.op.rd_addr != 5'd0));

endmodule

// File: rvfi_pipe_top.sv
module rvfi_pipe_top #(
    parameter int          IN_DEPTH    = 4,
    parameter int          OUT_CREDITS = 2,
    parameter logic [31:0] RESET_PC    = 32'h0
) (
    input  logic                    itf,
    input  logic                    rst,
    input  logic                    in_valid,
    input  logic [31:0]             in_inst,
    output logic                    in_credit,
    output logic                    out_valid,
    output rvfi_pipe_pkg::commit_t  out_rec,
    input  logic                    out_credit
);
    import rvfi_pipe_pkg::*;

    dec_op_t     dec;
    ex_res_t     res;
    logic        hold;
    logic [4:0]  rf_raddr1;
    logic [4:0]  rf_raddr2;
    logic [31:0] rf_rdata1;
    logic [31:0] rf_rdata2;

    // queue, decode, operand select
    rv_decode_stage #(
        .IN_DEPTH (IN_DEPTH),
        .RESET_PC (RESET_PC)
    ) u_decode (
        .itf       (itf),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_inst   (in_inst),
        .in_credit (in_credit),
        .hold      (hold),
        .rf_raddr1 (rf_raddr1),
        .rf_raddr2 (rf_raddr2),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .fwd_ex    (res),
        .dec       (dec)
    );

    rv_execute_stage u_execute (
        .itf  (itf),
        .rst  (rst),
        .hold (hold),
        .dec  (dec),
        .res  (res)
    );

    // regfile and record port
    rv_commit_stage #(
        .OUT_CREDITS (OUT_CREDITS)
    ) u_commit (
        .itf        (itf),
        .rst        (rst),
        .res        (res),
        .rf_raddr1  (rf_raddr1),
        .rf_raddr2  (rf_raddr2),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .hold       (hold),
        .out_valid  (out_valid),
        .out_rec    (out_rec),
        .out_credit (out_credit)
    );

endmodule

// File: rvfi_pipe_tb_checks.svh
// stops the run after a failure
task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
endtask

task automatic report_mismatch(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
    fail_run("record field mismatch");
endtask

// one retired record against the oldest model entry
task automatic check_record(input commit_t got);
    commit_t e;
    assert (exp_q.size() != 0) else fail_run("record arrived with no instruction outstanding");
    e = exp_q.pop_front();
    assert (got.order == e.order) else report_mismatch("order", got.order, e.order);
    assert (got.inst == e.inst) else report_mismatch("inst", 64'(got.inst), 64'(e.inst));
    assert (got.pc_rdata == e.pc_rdata)
        else report_mismatch("pc_rdata", 64'(got.pc_rdata), 64'(e.pc_rdata));
    assert (got.pc_wdata == e.pc_wdata)
        else report_mismatch("pc_wdata", 64'(got.pc_wdata), 64'(e.pc_wdata));
    assert (got.rs1_addr == e.rs1_addr)
        else report_mismatch("rs1_addr", 64'(got.rs1_addr), 64'(e.rs1_addr));
    assert (got.rs2_addr == e.rs2_addr)
        else report_mismatch("rs2_addr", 64'(got.rs2_addr), 64'(e.rs2_addr));
    assert (got.rs1_rdata == e.rs1_rdata)
        else report_mismatch("rs1_rdata", 64'(got.rs1_rdata), 64'(e.rs1_rdata));
    assert (got.rs2_rdata == e.rs2_rdata)
        else report_mismatch("rs2_rdata", 64'(got.rs2_rdata), 64'(e.rs2_rdata));
    assert (got.rd_addr == e.rd_addr)
        else report_mismatch("rd_addr", 64'(got.rd_addr), 64'(e.rd_addr));
    assert (got.rd_wdata == e.rd_wdata)
        else report_mismatch("rd_wdata", 64'(got.rd_wdata), 64'(e.rd_wdata));
    assert (got.load_regfile == e.load_regfile)
        else report_mismatch("load_regfile", 64'(got.load_regfile), 64'(e.load_regfile));
    assert (got.trap == e.trap) else report_mismatch("trap", 64'(got.trap), 64'(e.trap));
    assert (got.halt == e.halt) else report_mismatch("halt", 64'(got.halt), 64'(e.halt));
endtask

task automatic stop_input();
    @(posedge itf);
    in_valid <= 1'b0;
endtask

// every expected record retired
task automatic wait_drain();
    int waited;
    stop_input();
    waited = 0;
    while (exp_q.size() != 0) begin
        @(negedge itf);
        waited++;
        assert (waited < TIMEOUT) else fail_run("pipeline did not drain in time");
    end
endtask

// File: rvfi_pipe_tb.sv
module rvfi_pipe_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rvfi_pipe_pkg::*;

    localparam int          IN_DEPTH    = 4;
    localparam int          OUT_CREDITS = 2;
    localparam logic [31:0] RESET_PC    = 32'h0000_0100;
    localparam int          TIMEOUT     = 200;

    logic        itf;
    logic        rst;
    logic        in_valid;
    logic [31:0] in_inst;
    logic        in_credit;
    logic        out_valid;
    commit_t     out_rec;
    logic        out_credit;

    // reference model state
    logic [31:0] model_regs [32];
    logic [31:0] model_pc;
    logic [63:0] model_order;
    commit_t     exp_q [$];

    int          in_credits;
    int          owed;
    int          received;
    bit          withhold;
    logic [31:0] lcg_state;

    rvfi_pipe_top #(
        .IN_DEPTH    (IN_DEPTH),
        .OUT_CREDITS (OUT_CREDITS),
        .RESET_PC    (RESET_PC)
    ) uut (
        .itf        (itf),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_inst    (in_inst),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_rec    (out_rec),
        .out_credit (out_credit)
    );

    `include "rvfi_pipe_tb_checks.svh"

    initial begin
        itf = 1'b0;
        forever #20 itf = ~itf;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper bits of the lcg are the better ones
    function automatic logic [4:0] rand_reg(input int lo, input int span);
        return 5'(lo + int'(next_rand() >> 8) % span);
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // rv32i integer semantics, alt selects sub or sra
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] y;
        case (f3)
            3'd0:    y = alt ? a - b : a + b;
            3'd1:    y = a << b[4:0];
            3'd2:    y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    y = (a < b) ? 32'd1 : 32'd0;
            3'd4:    y = a ^ b;
            3'd5:    y = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    y = a | b;
            default: y = a & b;
        endcase
        return y;
    endfunction

    // expected record from the isa rules, then advance the model
    task automatic model_step(input logic [31:0] inst);
        commit_t     e;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] y;
        logic        legal;
        logic        writes;
        rd     = inst[11:7];
        f3     = inst[14:12];
        rs1    = inst[19:15];
        rs2    = inst[24:20];
        f7     = inst[31:25];
        e      = '0;
        y      = 32'd0;
        legal  = 1'b1;
        writes = 1'b0;
        e.order    = model_order;
        e.inst     = inst;
        e.pc_rdata = model_pc;
        e.pc_wdata = model_pc + 32'd4;
        case (inst[6:0])
            7'h33: begin
                e.rs1_addr = rs1;
                e.rs2_addr = rs2;
                legal  = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                y      = alu_ref(f3, f7[5], model_regs[rs1], model_regs[rs2]);
                writes = 1'b1;
            end
            7'h13: begin
                e.rs1_addr = rs1;
                if (f3 == 3'd1) begin
                    legal = (f7 == 7'h00);
                end else if (f3 == 3'd5) begin
                    legal = (f7 == 7'h00) || (f7 == 7'h20);
                end
                // no sub form for immediates
                y = alu_ref(f3, (f3 == 3'd5) && f7[5], model_regs[rs1],
                            {{20{inst[31]}}, inst[31:20]});
                writes = 1'b1;
            end
            7'h37: begin
                y      = {inst[31:12], 12'h000};
                writes = 1'b1;
            end
            7'h17: begin
                y      = model_pc + {inst[31:12], 12'h000};
                writes = 1'b1;
            end
            7'h73: begin
                legal  = (inst == 32'h0000_0073);
                e.halt = legal;
            end
            default: legal = 1'b0;
        endcase
        // unused sources read as x0
        e.rs1_rdata    = model_regs[e.rs1_addr];
        e.rs2_rdata    = model_regs[e.rs2_addr];
        e.trap         = !legal;
        e.load_regfile = writes && legal && (rd != 5'd0);
        if (e.load_regfile) begin
            e.rd_addr       = rd;
            e.rd_wdata      = y;
            model_regs[rd]  = y;
        end
        exp_q.push_back(e);
        model_pc    = model_pc + 32'd4;
        model_order = model_order + 64'd1;
    endtask

    // waits for an input credit, then drives one instruction
    task automatic send_inst(input logic [31:0] inst);
        int waited;
        waited = 0;
        while (in_credits == 0) begin
            @(posedge itf);
            in_valid <= 1'b0;
            waited++;
            assert (waited < TIMEOUT) else fail_run("no input credit came back in time");
        end
        @(posedge itf);
        in_valid <= 1'b1;
        in_inst  <= inst;
        in_credits--;
        model_step(inst);
    endtask

    // lui plus addi, upper part rounded for the sign of the low half
    task automatic load_value(input logic [4:0] rd, input logic [31:0] value);
        logic [19:0] upper;
        upper = value[31:12] + {19'd0, value[11]};
        send_inst(u_type(upper, rd, 7'h37));
        send_inst(i_type(value[11:0], rd, 3'd0, rd));
    endtask

    // retirement, credit return and input credit tracking
    always @(posedge itf) begin
        if (rst) begin
            out_credit <= 1'b0;
            owed = 0;
        end else begin
            if (out_valid) begin
                check_record(out_rec);
                received++;
                owed++;
            end
            if (in_credit) begin
                in_credits++;
            end
            if (!withhold && owed > 0) begin
                out_credit <= 1'b1;
                owed--;
            end else begin
                out_credit <= 1'b0;
            end
        end
    end

    task automatic test_reset_state();
        repeat (5) begin
            @(negedge itf);
            assert (out_valid == 1'b0) else report_mismatch("out_valid", 64'(out_valid), 64'd0);
            assert (in_credit == 1'b0) else report_mismatch("in_credit", 64'(in_credit), 64'd0);
        end
        for (int i = 1; i <= IN_DEPTH; i++) begin
            send_inst(u_type(20'(next_rand()), 5'(i), 7'h37));
        end
        wait_drain();
        // every queued instruction gave its credit back
        assert (in_credits == IN_DEPTH) else fail_run("input credits not all returned");
    endtask

    task automatic test_alu_ops();
        logic [4:0]  src;
        logic [11:0] imm;
        load_value(5'd5, next_rand());
        load_value(5'd6, next_rand());
        for (int f3 = 0; f3 < 8; f3++) begin
            send_inst(r_type(7'h00, 5'd6, 5'd5, 3'(f3), rand_reg(7, 9)));
            if (f3 == 0 || f3 == 5) begin
                send_inst(r_type(7'h20, 5'd6, 5'd5, 3'(f3), rand_reg(7, 9)));
            end
        end
        for (int f3 = 0; f3 < 8; f3++) begin
            src = next_rand() & 32'h100 ? 5'd5 : 5'd6;
            imm = 12'(next_rand() >> 12);
            if (f3 == 1 || f3 == 5) begin
                imm = {7'h00, imm[4:0]};
            end
            send_inst(i_type(imm, src, 3'(f3), rand_reg(7, 9)));
            if (f3 == 5) begin
                send_inst(i_type({7'h20, imm[4:0]}, src, 3'd5, rand_reg(7, 9)));
            end
        end
        wait_drain();
    endtask

    // each step reads the previous rd (execute) and the one before (commit)
    task automatic test_dependence_chain();
        logic [4:0] p;
        logic [4:0] pp;
        logic [4:0] rd;
        load_value(5'd16, next_rand());
        load_value(5'd17, next_rand());
        pp = 5'd16;
        p  = 5'd17;
        for (int i = 0; i < 12; i++) begin
            rd = 5'(18 + i % 4);
            case (i % 4)
                0: send_inst(r_type(7'h00, pp, p, 3'd0, rd));
                1: send_inst(r_type(7'h20, pp, p, 3'd0, rd));
                2: send_inst(i_type(12'(next_rand() >> 20), p, 3'd4, rd));
                default: send_inst(r_type(7'h00, pp, p, 3'd6, rd));
            endcase
            pp = p;
            p  = rd;
        end
        send_inst(r_type(7'h00, 5'd18, 5'd16, 3'd0, 5'd22));
        wait_drain();
    endtask

    task automatic test_x0_and_trap();
        send_inst(i_type(12'h123, 5'd5, 3'd0, 5'd0));
        send_inst(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd23));
        send_inst(r_type(7'h00, 5'd6, 5'd5, 3'd6, 5'd0));
        send_inst(r_type(7'h00, 5'd5, 5'd0, 3'd0, 5'd26));
        load_value(5'd24, next_rand());
        // custom-0 opcode with rd x24 must not write
        send_inst({20'(next_rand() >> 12), 5'd24, 7'h0b});
        send_inst(i_type(12'h000, 5'd24, 3'd0, 5'd25));
        wait_drain();
    endtask

    task automatic test_back_pressure();
        int base;
        withhold = 1'b1;
        base     = received;
        for (int i = 0; i < 6; i++) begin
            send_inst(i_type(12'(next_rand() >> 16), 5'd5, 3'd0, 5'(27 + i % 5)));
        end
        stop_input();
        repeat (40) begin
            @(negedge itf);
            assert (received - base <= OUT_CREDITS) else fail_run("records sent without credit");
        end
        assert (received - base == OUT_CREDITS) else fail_run("stalled output used too few credits");
        withhold = 1'b0;
        wait_drain();
    endtask

    task automatic test_ecall_auipc();
        send_inst(u_type(20'(next_rand()), 5'd20, 7'h17));
        send_inst(u_type(20'(next_rand()), 5'd21, 7'h17));
        send_inst(r_type(7'h00, 5'd21, 5'd20, 3'd0, 5'd22));
        send_inst(32'h0000_0073);
        wait_drain();
    endtask

    initial begin
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_inst     = 32'd0;
        out_credit  = 1'b0;
        withhold    = 1'b0;
        in_credits  = IN_DEPTH;
        received    = 0;
        lcg_state   = 32'h0b762784;
        model_pc    = RESET_PC;
        model_order = 64'd0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'd0;
        end
        repeat (3) @(posedge itf);
        rst <= 1'b0;
        test_reset_state();
        test_alu_ops();
        test_dependence_chain();
        test_x0_and_trap();
        test_back_pressure();
        test_ecall_auipc();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: rvfi_pipe.f
+incdir+.
rvfi_pipe_pkg.sv
rv_decode_stage.sv
rv_execute_stage.sv
rv_commit_stage.sv
rvfi_pipe_top.sv
rvfi_pipe_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f rvfi_pipe.f \
    --top-module rvfi_pipe_tb -o rvfi_pipe_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

./obj_dir/rvfi_pipe_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "TEST FAILED" "$SIM_LOG"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
if ! grep -q "TEST PASSED" "$SIM_LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
